/* source/dcache_cfg_pkg.sv */
// data cache geometry constants and address-field vector types, imported by every cache block
`default_nettype none

package dcache_cfg_pkg;

   // address and data widths
   localparam int ADDR_W        = 32;    // byte address
   localparam int WORD_W        = 32;    // one data word

   // organization
   localparam int N_SETS        = 8;
   localparam int N_WAYS        = 2;     // way A is 0, way B is 1
   localparam int WORDS_PER_BLK = 2;

   // address fields, msb to lsb: tag | idx | blkoff | byte
   localparam int IDX_W         = $clog2(N_SETS);
   localparam int BLK_W         = $clog2(WORDS_PER_BLK);
   localparam int BYTE_W        = 2;
   localparam int TAG_W         = ADDR_W - IDX_W - BLK_W - BYTE_W;  // 26 with the values above

   // data words and full byte addresses
   typedef logic [WORD_W-1:0] word_t;

   // upper address bits kept per frame
   typedef logic [TAG_W-1:0] tag_t;

   // set index
   typedef logic [IDX_W-1:0] idx_t;

   // word select inside a block
   typedef logic [BLK_W-1:0] blkoff_t;

endpackage

`default_nettype wire

/* source/dcache_bus_pkg.sv */
// port structs of the data cache and its frame layout, imported wherever those buses are used
`default_nettype none

package dcache_bus_pkg;

   import dcache_cfg_pkg::*;

   // byte address split into its cache fields
   typedef struct packed {
      tag_t                tag;
      idx_t                idx;
      blkoff_t             blkoff;
      logic [BYTE_W-1:0]   bytes;   // ignored, accesses are word wide
   } dcache_addr_t;

   // processor request, held until dhit
   typedef struct packed {
      logic          ren;
      logic          wen;
      logic          halt;
      dcache_addr_t  addr;
      word_t         wdata;
   } cpu_req_t;

   typedef struct packed {
      logic    dhit;
      logic    flushed;
      word_t   rdata;
   } cpu_rsp_t;

   // memory side, strobes held steady while dwait is high
   typedef struct packed {
      logic    dren;
      logic    dwen;
      word_t   daddr;
      word_t   dstore;
   } mem_req_t;

   typedef struct packed {
      logic    dwait;
      word_t   dload;
   } mem_rsp_t;

   // one cache line
   typedef struct packed {
      logic                         valid;
      logic                         dirty;
      tag_t                         tag;
      word_t [WORDS_PER_BLK-1:0]    data;
   } frame_t;

   // whole-frame write from the controller into storage
   typedef struct packed {
      logic    way;
      idx_t    idx;
      frame_t  frame;
      logic    we;
   } frame_wr_t;

   typedef enum logic [3:0] {
      IDLE, WBACK1, WBACK2, FILL1, FILL2, FLUSH_SCAN, FLUSH1, FLUSH2, FLUSHED
   } dcache_state_t;

endpackage

`default_nettype wire

/* source/dcache_frames.sv */
// frame storage for both ways, read at the request set and the flush set, written one frame at a time
`timescale 1ns/1ps
`default_nettype none

module dcache_frames
   import dcache_cfg_pkg::*, dcache_bus_pkg::*;
(
   input  logic                  CLK,
   input  logic                  nRST,

   // read side
   input  idx_t                  rd_idx,        // set of the current processor request
   input  idx_t                  flush_idx,     // set under the flush pointer

   // write side
   input  frame_wr_t             wr,

   output frame_t [N_WAYS-1:0]   set_frames,
   output frame_t [N_WAYS-1:0]   flush_frames
);

   // one storage array per way
   for (genvar w = 0; w < N_WAYS; w++) begin : g_way

      frame_t  mem [N_SETS];
      logic    way_we;

      // only the way named by the request takes the write
      assign way_we = wr.we && (wr.way == 1'(w));

      always_ff @(posedge CLK, negedge nRST) begin
         if (!nRST) begin
            // cold cache, every frame invalid and clean
            for (int s = 0; s < N_SETS; s++) begin
               mem[s] <= '0;
            end
         end else if (way_we) begin
            mem[wr.idx] <= wr.frame;   // tag, flags and both words together
         end
      end

      // two independent read ports
      assign set_frames[w]   = mem[rd_idx];
      assign flush_frames[w] = mem[flush_idx];

   end

endmodule

`default_nettype wire

/* source/dcache_lookup.sv */
// tag compare and LRU replacement for the addressed set, giving hit way and victim to the controller
`timescale 1ns/1ps
`default_nettype none

module dcache_lookup
   import dcache_cfg_pkg::*, dcache_bus_pkg::*;
(
   input  logic                  CLK,
   input  logic                  nRST,

   input  dcache_addr_t          addr,
   input  frame_t [N_WAYS-1:0]   set_frames,

   // access completed, mark this way most recently used
   input  logic                  lru_touch,
   input  logic                  touch_way,

   output logic                  hit,
   output logic                  hit_way,
   output logic                  victim_way,
   output frame_t                victim
);

   logic [N_WAYS-1:0]   match;
   logic [N_SETS-1:0]   lru;       // per set, the least recently used way
   logic                lru_way;

   // a tag match only counts on a valid frame
   always_comb begin
      for (int w = 0; w < N_WAYS; w++) begin
         match[w] = set_frames[w].valid && (set_frames[w].tag == addr.tag);
      end
   end

   assign hit     = |match;
   assign hit_way = match[1];     // way A when neither matches
   assign lru_way = lru[addr.idx];

   // empty ways are used before any replacement, A first
   always_comb begin
      if (!set_frames[0].valid) begin
         victim_way = 1'b0;
      end else if (!set_frames[1].valid) begin
         victim_way = 1'b1;
      end else begin
         victim_way = lru_way;
      end
   end

   assign victim = set_frames[victim_way];

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         lru <= '0;
      end else if (lru_touch) begin
         lru[addr.idx] <= ~touch_way;   // the other way becomes the next victim
      end
   end

endmodule

`default_nettype wire

/* source/dcache_ctrl.sv */
// cache controller FSM for hits, victim write-back, block fill and the halt flush
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
   import dcache_cfg_pkg::*, dcache_bus_pkg::*;
(
   input  logic                  CLK,
   input  logic                  nRST,

   input  cpu_req_t              cpu_req,
   output cpu_rsp_t              cpu_rsp,
   output mem_req_t              mem_req,
   input  mem_rsp_t              mem_rsp,

   // from lookup
   input  logic                  hit,
   input  logic                  hit_way,
   input  logic                  victim_way,
   input  frame_t [N_WAYS-1:0]   set_frames,
   input  frame_t                victim,

   // flush scan
   input  frame_t [N_WAYS-1:0]   flush_frames,
   output idx_t                  flush_idx,

   output frame_wr_t             frame_wr,
   output logic                  lru_touch,
   output logic                  touch_way
);

   dcache_state_t       state, next_state;
   logic [IDX_W:0]      flush_cnt, next_flush_cnt;   // msb selects way B
   logic                flush_step;
   logic                flush_last;
   logic                req;
   frame_t              hit_frame;
   frame_t              scan_frame;
   word_t               fill_word;                   // first fetched word of a fill

   // word address of one word of a block
   function automatic word_t blk_addr(tag_t tag, idx_t idx, blkoff_t off);
      dcache_addr_t a;
      a.tag    = tag;
      a.idx    = idx;
      a.blkoff = off;
      a.bytes  = '0;
      return word_t'(a);
   endfunction

   assign req        = cpu_req.ren | cpu_req.wen;
   assign hit_frame  = set_frames[hit_way];
   assign flush_idx  = flush_cnt[IDX_W-1:0];
   assign scan_frame = flush_frames[flush_cnt[IDX_W]];
   assign flush_last = &flush_cnt;

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         state     <= IDLE;
         flush_cnt <= '0;
      end else begin
         state     <= next_state;
         flush_cnt <= next_flush_cnt;
      end
   end

   always_ff @(posedge CLK) begin
      if (state == FILL1 && !mem_rsp.dwait) begin
         fill_word <= mem_rsp.dload;
      end
   end

   always_comb begin
      next_state     = state;
      next_flush_cnt = flush_cnt;
      flush_step     = 1'b0;
      cpu_rsp        = '0;
      cpu_rsp.rdata  = hit_frame.data[cpu_req.addr.blkoff];
      mem_req        = '0;
      frame_wr       = '0;
      lru_touch      = 1'b0;
      touch_way      = hit_way;

      case (state)
         IDLE: begin
            if (cpu_req.halt) begin
               next_state = FLUSH_SCAN;
            end else if (req && hit) begin
               cpu_rsp.dhit = 1'b1;
               lru_touch    = 1'b1;
               if (cpu_req.wen) begin   // merge the store into the hit line
                  frame_wr.we          = 1'b1;
                  frame_wr.way         = hit_way;
                  frame_wr.idx         = cpu_req.addr.idx;
                  frame_wr.frame       = hit_frame;
                  frame_wr.frame.dirty = 1'b1;
                  frame_wr.frame.data[cpu_req.addr.blkoff] = cpu_req.wdata;
               end
            end else if (req) begin
               next_state = (victim.valid && victim.dirty) ? WBACK1 : FILL1;
            end
         end
         WBACK1: begin
            mem_req.dwen   = 1'b1;
            mem_req.daddr  = blk_addr(victim.tag, cpu_req.addr.idx, 1'b0);
            mem_req.dstore = victim.data[0];
            if (!mem_rsp.dwait) begin
               next_state = WBACK2;
            end
         end
         WBACK2: begin
            mem_req.dwen   = 1'b1;
            mem_req.daddr  = blk_addr(victim.tag, cpu_req.addr.idx, 1'b1);
            mem_req.dstore = victim.data[1];
            if (!mem_rsp.dwait) begin
               // victim now matches memory
               frame_wr.we          = 1'b1;
               frame_wr.way         = victim_way;
               frame_wr.idx         = cpu_req.addr.idx;
               frame_wr.frame       = victim;
               frame_wr.frame.dirty = 1'b0;
               next_state           = FILL1;
            end
         end
         FILL1: begin
            mem_req.dren  = 1'b1;
            mem_req.daddr = blk_addr(cpu_req.addr.tag, cpu_req.addr.idx, 1'b0);
            if (!mem_rsp.dwait) begin
               next_state = FILL2;
            end
         end
         FILL2: begin
            mem_req.dren  = 1'b1;
            mem_req.daddr = blk_addr(cpu_req.addr.tag, cpu_req.addr.idx, 1'b1);
            if (!mem_rsp.dwait) begin
               // whole line lands at once, the victim choice stays put during the fill
               frame_wr.we          = 1'b1;
               frame_wr.way         = victim_way;
               frame_wr.idx         = cpu_req.addr.idx;
               frame_wr.frame.valid = 1'b1;
               frame_wr.frame.dirty = 1'b0;
               frame_wr.frame.tag   = cpu_req.addr.tag;
               frame_wr.frame.data  = {mem_rsp.dload, fill_word};
               next_state           = IDLE;
            end
         end
         FLUSH_SCAN: begin
            if (scan_frame.valid && scan_frame.dirty) begin
               next_state = FLUSH1;
            end else begin
               flush_step = 1'b1;
            end
         end
         FLUSH1: begin
            mem_req.dwen   = 1'b1;
            mem_req.daddr  = blk_addr(scan_frame.tag, flush_idx, 1'b0);
            mem_req.dstore = scan_frame.data[0];
            if (!mem_rsp.dwait) begin
               next_state = FLUSH2;
            end
         end
         FLUSH2: begin
            mem_req.dwen   = 1'b1;
            mem_req.daddr  = blk_addr(scan_frame.tag, flush_idx, 1'b1);
            mem_req.dstore = scan_frame.data[1];
            flush_step     = !mem_rsp.dwait;
         end
         FLUSHED: begin
            cpu_rsp.flushed = 1'b1;   // held until reset
         end
         default: begin
            next_state = IDLE;
         end
      endcase

      // move the scan pointer, way A sets first, then way B
      if (flush_step) begin
         if (flush_last) begin
            next_state = FLUSHED;
         end else begin
            next_state     = FLUSH_SCAN;
            next_flush_cnt = flush_cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* source/dcache.sv */
// data cache top level, connects frame storage, lookup and controller between processor and memory
`timescale 1ns/1ps
`default_nettype none

module dcache
   import dcache_cfg_pkg::*, dcache_bus_pkg::*;
(
   input  logic      CLK,
   input  logic      nRST,

   input  cpu_req_t  cpu_req,
   output cpu_rsp_t  cpu_rsp,

   output mem_req_t  mem_req,
   input  mem_rsp_t  mem_rsp
);

   frame_t [N_WAYS-1:0]   set_frames;
   frame_t [N_WAYS-1:0]   flush_frames;
   frame_t                victim;
   frame_wr_t             frame_wr;
   idx_t                  flush_idx;
   logic                  hit;
   logic                  hit_way;
   logic                  victim_way;
   logic                  lru_touch;
   logic                  touch_way;

   dcache_frames i_frames (
      .CLK          (CLK),
      .nRST         (nRST),
      .rd_idx       (cpu_req.addr.idx),   // request set read straight from the address
      .flush_idx    (flush_idx),
      .wr           (frame_wr),
      .set_frames   (set_frames),
      .flush_frames (flush_frames)
   );

   dcache_lookup i_lookup (
      .CLK        (CLK),
      .nRST       (nRST),
      .addr       (cpu_req.addr),
      .set_frames (set_frames),
      .lru_touch  (lru_touch),
      .touch_way  (touch_way),
      .hit        (hit),
      .hit_way    (hit_way),
      .victim_way (victim_way),
      .victim     (victim)
   );

   dcache_ctrl i_ctrl (
      .CLK          (CLK),
      .nRST         (nRST),
      .cpu_req      (cpu_req),
      .cpu_rsp      (cpu_rsp),
      .mem_req      (mem_req),
      .mem_rsp      (mem_rsp),
      .hit          (hit),
      .hit_way      (hit_way),
      .victim_way   (victim_way),
      .set_frames   (set_frames),
      .victim       (victim),
      .flush_frames (flush_frames),
      .flush_idx    (flush_idx),
      .frame_wr     (frame_wr),
      .lru_touch    (lru_touch),
      .touch_way    (touch_way)
   );

endmodule

`default_nettype wire

/* verif/dcache_mem_model.sv */
// word-wide memory behind the data cache for the testbench, with fixed wait states and a write log
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_model
   import dcache_cfg_pkg::*, dcache_bus_pkg::*;
(
   input  logic      CLK,
   input  logic      nRST,

   input  mem_req_t  mem_req,
   output mem_rsp_t  mem_rsp
);

   localparam int WAIT_CYCLES = 2;   // dwait high this long before each beat

   word_t         mem [word_t];      // only written words live here
   word_t         log_addr [$];
   word_t         log_data [$];
   int            read_count;
   int unsigned   wait_cnt;
   word_t         rd_data;

   // content of a word that was never written
   function automatic word_t fill_pattern(word_t addr);
      return (addr >> 2) ^ 32'hA5A50000;
   endfunction

   function automatic word_t read_word(word_t addr);
      if (mem.exists(addr)) begin
         return mem[addr];
      end
      return fill_pattern(addr);
   endfunction

   always_comb begin
      mem_rsp.dwait = !((mem_req.dren || mem_req.dwen) && (wait_cnt == WAIT_CYCLES));
      mem_rsp.dload = rd_data;
   end

   always @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         wait_cnt   <= 0;
         read_count <= 0;
      end else if (mem_req.dren || mem_req.dwen) begin
         rd_data <= read_word(mem_req.daddr);   // address is held, so ready by the beat
         if (wait_cnt == WAIT_CYCLES) begin
            wait_cnt <= 0;   // beat completes this cycle
            if (mem_req.dwen) begin
               mem[mem_req.daddr] = mem_req.dstore;
               log_addr.push_back(mem_req.daddr);
               log_data.push_back(mem_req.dstore);
            end else begin
               read_count <= read_count + 1;
            end
         end else begin
            wait_cnt <= wait_cnt + 1;
         end
      end else begin
         wait_cnt <= 0;
      end
   end

endmodule

`default_nettype wire

/* verif/dcache_assert.sv */
// concurrent checks on the cache controller, bound into every dcache_ctrl instance
`timescale 1ns/1ps
`default_nettype none

module dcache_assert
   import dcache_bus_pkg::*;
(
   input  logic            CLK,
   input  logic            nRST,
   input  dcache_state_t   state,
   input  mem_req_t        mem_req,
   input  cpu_rsp_t        cpu_rsp
);

   int n_fail = 0;   // assertion failures so far

   // one memory transfer at a time
   a_one_strobe: assert property (@(posedge CLK) disable iff (!nRST)
      !(mem_req.dren && mem_req.dwen))
      else begin
         $error("dren and dwen high together");
         n_fail++;
      end

   a_word_aligned: assert property (@(posedge CLK) disable iff (!nRST)
      (mem_req.dren || mem_req.dwen) |-> (mem_req.daddr[1:0] == 2'b00))
      else begin
         $error("memory address not word aligned");
         n_fail++;
      end

   // flushed holds until reset
   a_flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST)
      cpu_rsp.flushed |=> cpu_rsp.flushed)
      else begin
         $error("flushed dropped before reset");
         n_fail++;
      end

   a_hit_in_idle: assert property (@(posedge CLK) disable iff (!nRST)
      (state != IDLE) |-> !cpu_rsp.dhit)
      else begin
         $error("dhit raised outside IDLE");
         n_fail++;
      end

endmodule

bind dcache_ctrl dcache_assert i_assert (
   .CLK     (CLK),
   .nRST    (nRST),
   .state   (state),
   .mem_req (mem_req),
   .cpu_rsp (cpu_rsp)
);

`default_nettype wire

/* verif/dcache_tb.sv */
// testbench for the data cache, runs directed and random accesses against a shadow memory, then a flush
`timescale 1ns/1ps
`default_nettype none

module dcache_tb
   import dcache_cfg_pkg::*, dcache_bus_pkg::*;
();

   localparam int          CLK_HALF       = 4;
   localparam int          RESET_CYCLES   = 8;
   localparam int          N_DIRECTED     = 10;
   localparam int          N_RANDOM       = 200;
   localparam int          POOL_WORDS     = 24;
   // worst access is a dirty miss, four beats of three cycles, flush is at most 16 blocks
   localparam int          TIMEOUT_CYCLES = (N_DIRECTED + N_RANDOM) * 40 + 400 + RESET_CYCLES;
   localparam logic [15:0] LFSR_SEED      = 16'd2795;
   localparam tag_t        RAND_TAG       = 26'h10;

   logic          CLK = 1'b0;
   logic          nRST;
   cpu_req_t      cpu_req;
   cpu_rsp_t      cpu_rsp;
   mem_req_t      mem_req;
   mem_rsp_t      mem_rsp;

   word_t         shadow [word_t];        // stored words by byte address
   word_t         exp_rdata;
   string         cur_test  = "reset";
   logic [15:0]   lfsr      = LFSR_SEED;
   int            cycle_cnt = 0;

   dcache i_dut (
      .CLK     (CLK),
      .nRST    (nRST),
      .cpu_req (cpu_req),
      .cpu_rsp (cpu_rsp),
      .mem_req (mem_req),
      .mem_rsp (mem_rsp)
   );

   dcache_mem_model i_mem (
      .CLK     (CLK),
      .nRST    (nRST),
      .mem_req (mem_req),
      .mem_rsp (mem_rsp)
   );

   always #CLK_HALF CLK = ~CLK;

   // memory content before any store
   function automatic word_t init_word(word_t addr);
      return (addr >> 2) ^ 32'hA5A50000;
   endfunction

   function automatic word_t expected_load(word_t addr);
      if (shadow.exists(addr)) begin
         return shadow[addr];
      end
      return init_word(addr);
   endfunction

   function automatic word_t make_addr(tag_t tag, idx_t idx, blkoff_t off);
      return {tag, idx, off, 2'b00};
   endfunction

   // word p of the random pool, three tags in every set
   function automatic word_t pool_addr(int p);
      int tsel;
      tsel = p / N_SETS;
      return make_addr(RAND_TAG + tag_t'(tsel), idx_t'(p % N_SETS), blkoff_t'(tsel % 2));
   endfunction

   function automatic logic [15:0] lfsr_step(logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16 + x^14 + x^13 + x^11 + 1
   endfunction

   task automatic rand_bits(input int n, output word_t v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[WORD_W-2:0], lfsr[0]};
      end
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (exp !== act) begin
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
         $display("tests failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
         $display("tests failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // called 1 ns after a rising edge, returns 1 ns after the edge that took the access
   task automatic access(input string name, input logic wr, input word_t addr, input word_t wdata);
      logic done;
      cur_test      = name;
      exp_rdata     = expected_load(addr);
      cpu_req.ren   = !wr;
      cpu_req.wen   = wr;
      cpu_req.addr  = dcache_addr_t'(addr);
      cpu_req.wdata = wdata;
      done          = 1'b0;
      while (!done) begin
         @(negedge CLK);
         done = cpu_rsp.dhit;
      end
      if (wr) begin
         shadow[addr] = wdata;
      end
      @(posedge CLK);
      #1;
      cpu_req.ren = 1'b0;
      cpu_req.wen = 1'b0;
   endtask

   // load data compared mid cycle, when dhit and rdata have settled
   always @(negedge CLK) begin
      if (nRST && cpu_req.ren && cpu_rsp.dhit) begin
         check_word(cur_test, exp_rdata, cpu_rsp.rdata);
      end
   end

   // controller assertions, the first one that fires ends the run
   always @(negedge CLK) begin
      if (i_dut.i_ctrl.i_assert.n_fail != 0) begin
         $display("controller assertion failed in test %s", cur_test);
         $display("tests failed");
         $fatal(1, "assertion failure");
      end
   end

   always @(posedge CLK) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > TIMEOUT_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("tests failed");
         $fatal(1, "run stopped by the cycle limit");
      end
   end

   initial begin
      word_t   pick;
      word_t   op;
      word_t   wd;
      word_t   reads_before;
      word_t   addr_a;
      word_t   addr_b;
      word_t   addr_c;
      int      log_before;
      logic    done;

      cpu_req = '0;
      nRST    = 1'b0;
      repeat (RESET_CYCLES) @(posedge CLK);
      #1;
      nRST = 1'b1;

      // cold read, then the other word of the block without a memory read
      access("cold_read", 1'b0, make_addr(26'h40, 3'd1, 1'b0), '0);
      reads_before = word_t'(i_mem.read_count);
      access("cold_neighbour", 1'b0, make_addr(26'h40, 3'd1, 1'b1), '0);
      check_word("cold_neighbour_reads", reads_before, word_t'(i_mem.read_count));

      access("store", 1'b1, make_addr(26'h40, 3'd2, 1'b1), 32'h1234_5678);
      access("load_after_store", 1'b0, make_addr(26'h40, 3'd2, 1'b1), '0);

      // set 5, leave b dirty and least recently used so c pushes it out
      addr_a = make_addr(26'h41, 3'd5, 1'b0);
      addr_b = make_addr(26'h42, 3'd5, 1'b0);
      addr_c = make_addr(26'h43, 3'd5, 1'b0);
      access("lru_read_a", 1'b0, addr_a, '0);
      access("lru_read_b", 1'b0, addr_b, '0);
      access("lru_store_b", 1'b1, addr_b, 32'hCAFE_0B0B);
      access("lru_read_a_again", 1'b0, addr_a, '0);
      log_before = i_mem.log_addr.size();
      access("lru_read_c", 1'b0, addr_c, '0);
      check_word("lru_wb_count", word_t'(log_before + 2), word_t'(i_mem.log_addr.size()));
      check_word("lru_wb_addr0", addr_b, i_mem.log_addr[log_before]);
      check_word("lru_wb_data0", expected_load(addr_b), i_mem.log_data[log_before]);
      check_word("lru_wb_addr1", addr_b + 4, i_mem.log_addr[log_before + 1]);
      check_word("lru_wb_data1", expected_load(addr_b + 4), i_mem.log_data[log_before + 1]);
      access("lru_read_b_back", 1'b0, addr_b, '0);

      for (int i = 0; i < N_RANDOM; i++) begin
         rand_bits(5, pick);
         rand_bits(1, op);
         rand_bits(WORD_W, wd);
         access("random", op[0], pool_addr(int'(pick) % POOL_WORDS), wd);
      end

      // halt stays up until the flush is done
      cur_test     = "flush";
      cpu_req.halt = 1'b1;
      done         = 1'b0;
      while (!done) begin
         @(negedge CLK);
         done = cpu_rsp.flushed;
      end
      repeat (4) begin
         @(negedge CLK);
         check_flag("flushed_hold", 1'b1, cpu_rsp.flushed);
      end
      // both words of every stored block, the only blocks that can be written back
      foreach (shadow[a]) begin
         check_word("flush_memory", shadow[a], i_mem.read_word(a));
         check_word("flush_memory", expected_load(a ^ 32'h4), i_mem.read_word(a ^ 32'h4));
      end

      if (i_dut.i_ctrl.i_assert.n_fail != 0) begin
         $display("controller assertions failed %0d times", i_dut.i_ctrl.i_assert.n_fail);
         $display("tests failed");
         $fatal(1, "assertion failures");
      end else begin
         $display("all tests passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* tb.f */
source/dcache_cfg_pkg.sv
source/dcache_bus_pkg.sv
source/dcache_frames.sv
source/dcache_lookup.sv
source/dcache_ctrl.sv
source/dcache.sv
verif/dcache_mem_model.sv
verif/dcache_assert.sv
verif/dcache_tb.sv
